// File: exec_stage.f
+incdir+verif
logic/exec_pkg.sv
logic/operand_select.sv
logic/exec_alu.sv
logic/barrel_shifter.sv
logic/muldiv_unit.sv
logic/exec_stage.sv
verif/exec_stage_tb.sv

// File: logic/barrel_shifter.sv
/*
 * barrel_shifter
 * SLL, SRL and SRA of operand B in log stages by A[4:0].
 */
`timescale 1ns/1ps

module barrel_shifter
(
    input  exec_pkg::exec_func_e func_i,
    input  exec_pkg::word_t      a_i,
    input  exec_pkg::word_t      b_i,
    output exec_pkg::word_t      y_o
);

    exec_pkg::word_t stg;
    logic            fill;

    always_comb
    begin
        fill = (func_i == exec_pkg::SRA) & b_i[31];    // sign fill for sra only
        stg  = b_i;
        for (int i = 0; i < exec_pkg::SHAMT_W; i++)
        begin
            if (a_i[i])
            begin
                if (func_i == exec_pkg::SLL)
                    stg = stg << (1 << i);
                else
                    stg = (stg >> (1 << i)) | ({32{fill}} & ~(32'hffff_ffff >> (1 << i)));
            end
        end
        case (func_i)
            exec_pkg::SLL, exec_pkg::SRL, exec_pkg::SRA:
                y_o = stg;
            default:
                y_o = '0;
        endcase
    end

endmodule

// File: logic/exec_alu.sv
/*
 * exec_alu
 * Pass, add/subtract, logic and set-less-than functions.
 * Drives zero for every function it does not own.
 */
`timescale 1ns/1ps

module exec_alu
(
    input  exec_pkg::exec_func_e func_i,
    input  exec_pkg::word_t      a_i,
    input  exec_pkg::word_t      b_i,
    output exec_pkg::word_t      y_o
);

    logic slt_s;
    logic slt_u;

    assign slt_s = $signed(a_i) < $signed(b_i);
    assign slt_u = a_i < b_i;

    always_comb
    begin
        case (func_i)
            exec_pkg::PA:
                y_o = a_i;
            exec_pkg::PB:
                y_o = b_i;
            exec_pkg::ADD:
                y_o = a_i + b_i;
            exec_pkg::SUB,
            exec_pkg::SUBU:
                y_o = a_i - b_i;        // no overflow trap here
            exec_pkg::OR:
                y_o = a_i | b_i;
            exec_pkg::AND:
                y_o = a_i & b_i;
            exec_pkg::XOR:
                y_o = a_i ^ b_i;
            exec_pkg::NOR:
                y_o = ~(a_i | b_i);
            exec_pkg::SLT:
                y_o = {31'd0, slt_s};
            exec_pkg::SLTU:
                y_o = {31'd0, slt_u};
            default:
                y_o = '0;
        endcase
    end

endmodule

// File: logic/exec_pkg.sv
/*
 * exec_pkg
 * Shared types of the MIPS execute stage: data words, function codes,
 * forwarding and source selects, and the issue/result structs.
 */
package exec_pkg;

    localparam int SHAMT_W = 5;     // shift amount field
    localparam int ITER_N  = 32;    // mul/div iterations

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    typedef enum logic [4:0] {
        NOP, PA, PB, ADD, SUB, SUBU,
        OR, AND, XOR, NOR, SLT, SLTU,
        SLL, SRL, SRA,
        MULT, MULTU, DIV, DIVU,
        MFHI, MFLO, MTHI, MTLO
    } exec_func_e;

    typedef enum logic [1:0] {
        NONE   = 2'd0,  // register file value
        FW_ALU = 2'd1,
        FW_MEM = 2'd2
    } fw_sel_e;

    typedef enum logic {
        REG = 1'b0,
        EXT = 1'b1      // extended immediate
    } src_sel_e;

    // decoded control word of one instruction
    typedef struct packed {
        exec_func_e func;
        src_sel_e   a_src;
        fw_sel_e    a_fw;
        src_sel_e   b_src;
        fw_sel_e    b_fw;
        fw_sel_e    st_fw;
    } exec_op_t;

    typedef struct packed {
        word_t rs;
        word_t rt;
        word_t ext;
        word_t fw_alu;
        word_t fw_mem;
    } exec_data_t;

    typedef struct packed {
        word_t result;
        word_t store_data;
    } exec_result_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,
        ST_DIV,
        ST_FIX          // sign fix and HI/LO write
    } muldiv_state_e;

endpackage

// File: logic/exec_stage.sv
/*
 * exec_stage
 * Execute stage top: issue handshake, operand muxes, the three
 * function units, and the registered result and store data.
 */
`timescale 1ns/1ps

module exec_stage
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   op_valid_i,
    input  exec_pkg::exec_op_t     op_i,
    input  exec_pkg::exec_data_t   data_i,
    output logic                   op_ready_o,
    output exec_pkg::exec_result_t result_o,
    output logic                   result_valid_o,
    output logic                   busy_o
);

    exec_pkg::word_t opa;
    exec_pkg::word_t opb;
    exec_pkg::word_t st_data;
    exec_pkg::word_t alu_y;
    exec_pkg::word_t sh_y;
    exec_pkg::word_t md_y;
    logic            md_busy;
    logic            accept;
    logic            has_result;

    operand_select u_opsel
    (
        .op_i    (op_i),
        .data_i  (data_i),
        .a_o     (opa),
        .b_o     (opb),
        .store_o (st_data)
    );

    exec_alu u_alu
    (
        .func_i (op_i.func),
        .a_i    (opa),
        .b_i    (opb),
        .y_o    (alu_y)
    );

    barrel_shifter u_shift
    (
        .func_i (op_i.func),
        .a_i    (opa),
        .b_i    (opb),
        .y_o    (sh_y)
    );

    muldiv_unit u_muldiv
    (
        .clk     (clk),
        .rst     (rst),
        .start_i (accept),
        .func_i  (op_i.func),
        .a_i     (opa),
        .b_i     (opb),
        .y_o     (md_y),
        .busy_o  (md_busy)
    );

    assign op_ready_o = ~md_busy;
    assign busy_o     = md_busy;
    assign accept     = op_valid_i & op_ready_o;
    assign has_result = op_i.func inside {[exec_pkg::PA : exec_pkg::SRA],
                                          exec_pkg::MFHI, exec_pkg::MFLO};

    always_ff @(posedge clk)
    begin
        if (!rst)
            result_valid_o <= 1'b0;
        else
            result_valid_o <= accept & has_result;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            result_o.result     <= alu_y | sh_y | md_y;    // idle units give zero
            result_o.store_data <= st_data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst) op_valid_i |-> !$isunknown(op_i.func));

endmodule

// File: logic/muldiv_unit.sv
/*
 * muldiv_unit
 * Iterative multiply (shift-add) and restoring divide on magnitudes,
 * a final sign-fix cycle, and the HI/LO registers with their moves.
 */
`timescale 1ns/1ps

module muldiv_unit
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_i,
    input  exec_pkg::exec_func_e func_i,
    input  exec_pkg::word_t      a_i,
    input  exec_pkg::word_t      b_i,
    output exec_pkg::word_t      y_o,
    output logic                 busy_o
);

    localparam int CNT_W = $clog2(exec_pkg::ITER_N);

    exec_pkg::muldiv_state_e state;
    logic [CNT_W-1:0]        cnt;
    exec_pkg::word_t         hi;
    exec_pkg::word_t         lo;
    exec_pkg::word_t         opd;       // multiplicand or divisor
    exec_pkg::dword_t        acc;       // product, or remainder:quotient
    logic                    neg_q;
    logic                    neg_r;
    logic                    was_mul;
    logic                    is_mul;
    logic                    is_div;
    logic                    is_sgn;
    exec_pkg::word_t         a_mag;
    exec_pkg::word_t         b_mag;
    logic [32:0]             mul_sum;
    logic [32:0]             rem_sh;
    logic [33:0]             div_diff;
    exec_pkg::dword_t        prod_fix;

    assign is_mul = (func_i == exec_pkg::MULT) || (func_i == exec_pkg::MULTU);
    assign is_div = (func_i == exec_pkg::DIV) || (func_i == exec_pkg::DIVU);
    assign is_sgn = (func_i == exec_pkg::MULT) || (func_i == exec_pkg::DIV);

    assign a_mag = (is_sgn && a_i[31]) ? ~a_i + 32'd1 : a_i;
    assign b_mag = (is_sgn && b_i[31]) ? ~b_i + 32'd1 : b_i;

    assign mul_sum  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, opd} : 33'd0);
    assign rem_sh   = acc[63:31];                     // remainder shifted with next bit
    assign div_diff = {1'b0, rem_sh} - {2'b00, opd};
    assign prod_fix = neg_q ? ~acc + 64'd1 : acc;

    assign busy_o = (state != exec_pkg::ST_IDLE);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state <= exec_pkg::ST_IDLE;
            cnt   <= '0;
            hi    <= '0;
            lo    <= '0;
        end
        else
        begin
            case (state)
                exec_pkg::ST_IDLE:
                begin
                    cnt <= '0;
                    if (start_i && is_mul)
                        state <= exec_pkg::ST_MUL;
                    else if (start_i && is_div)
                        state <= exec_pkg::ST_DIV;
                    if (start_i && func_i == exec_pkg::MTHI)
                        hi <= a_i;
                    if (start_i && func_i == exec_pkg::MTLO)
                        lo <= a_i;
                end
                exec_pkg::ST_MUL, exec_pkg::ST_DIV:
                begin
                    cnt <= cnt + CNT_W'(1);
                    if (cnt == CNT_W'(exec_pkg::ITER_N - 1))
                        state <= exec_pkg::ST_FIX;
                end
                exec_pkg::ST_FIX:
                begin
                    state <= exec_pkg::ST_IDLE;
                    if (was_mul)
                        {hi, lo} <= prod_fix;
                    else
                    begin
                        hi <= neg_r ? ~acc[63:32] + 32'd1 : acc[63:32];  // dividend sign
                        lo <= neg_q ? ~acc[31:0] + 32'd1 : acc[31:0];
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start_i)
        begin
            opd     <= is_div ? b_mag : a_mag;
            acc     <= {32'd0, is_div ? a_mag : b_mag};
            neg_q   <= is_sgn & (a_i[31] ^ b_i[31]);
            neg_r   <= is_sgn & a_i[31];
            was_mul <= is_mul;
        end
        else if (state == exec_pkg::ST_MUL)
            acc <= {mul_sum, acc[31:1]};
        else if (state == exec_pkg::ST_DIV)
            acc <= !div_diff[33] ? {div_diff[31:0], acc[30:0], 1'b1}
                                 : {rem_sh[31:0], acc[30:0], 1'b0};
    end

    always_comb
    begin
        case (func_i)
            exec_pkg::MFHI: y_o = hi;
            exec_pkg::MFLO: y_o = lo;
            default:        y_o = '0;
        endcase
    end

    // issue must be held off by the top while iterating
    assert property (@(posedge clk) disable iff (!rst) busy_o |-> !start_i);

endmodule

// File: logic/operand_select.sv
/*
 * operand_select
 * Forwarding and source muxes for operand A, operand B and store data.
 */
`timescale 1ns/1ps

module operand_select
(
    input  exec_pkg::exec_op_t   op_i,
    input  exec_pkg::exec_data_t data_i,
    output exec_pkg::word_t      a_o,
    output exec_pkg::word_t      b_o,
    output exec_pkg::word_t      store_o
);

    exec_pkg::word_t rs_fw;
    exec_pkg::word_t rt_fw;

    function automatic exec_pkg::word_t fw_pick(input exec_pkg::fw_sel_e sel,
                                                input exec_pkg::word_t v,
                                                input exec_pkg::exec_data_t d);
        case (sel)
            exec_pkg::FW_ALU: fw_pick = d.fw_alu;
            exec_pkg::FW_MEM: fw_pick = d.fw_mem;
            default:          fw_pick = v;
        endcase
    endfunction

    assign rs_fw   = fw_pick(op_i.a_fw, data_i.rs, data_i);
    assign rt_fw   = fw_pick(op_i.b_fw, data_i.rt, data_i);
    assign store_o = fw_pick(op_i.st_fw, data_i.rt, data_i);   // rt copy for stores

    assign a_o = (op_i.a_src == exec_pkg::EXT) ? data_i.ext : rs_fw;
    assign b_o = (op_i.b_src == exec_pkg::EXT) ? data_i.ext : rt_fw;

    always_comb
    begin
        if (!$isunknown(op_i))
            assert (op_i.a_fw != 2'b11 && op_i.b_fw != 2'b11 && op_i.st_fw != 2'b11)
            else $error("forwarding select uses reserved code");
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the execute stage testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f exec_stage.f --top-module exec_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vexec_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verif/exec_model.svh
/*
 * exec_model
 * Reference functions for operand muxing, every stage function and HI/LO updates.
 */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic exec_pkg::word_t fw_ref(input exec_pkg::fw_sel_e s,
                                           input exec_pkg::word_t v,
                                           input exec_pkg::exec_data_t d);
    if (s == exec_pkg::FW_ALU)
        return d.fw_alu;
    if (s == exec_pkg::FW_MEM)
        return d.fw_mem;
    return v;
endfunction

function automatic exec_pkg::word_t opa_ref(input exec_pkg::exec_op_t o,
                                            input exec_pkg::exec_data_t d);
    return (o.a_src == exec_pkg::EXT) ? d.ext : fw_ref(o.a_fw, d.rs, d);
endfunction

function automatic exec_pkg::word_t opb_ref(input exec_pkg::exec_op_t o,
                                            input exec_pkg::exec_data_t d);
    return (o.b_src == exec_pkg::EXT) ? d.ext : fw_ref(o.b_fw, d.rt, d);
endfunction

function automatic logic has_result_ref(input exec_pkg::exec_func_e f);
    case (f)
        exec_pkg::PA, exec_pkg::PB, exec_pkg::ADD, exec_pkg::SUB, exec_pkg::SUBU,
        exec_pkg::OR, exec_pkg::AND, exec_pkg::XOR, exec_pkg::NOR, exec_pkg::SLT,
        exec_pkg::SLTU, exec_pkg::SLL, exec_pkg::SRL, exec_pkg::SRA,
        exec_pkg::MFHI, exec_pkg::MFLO:
            return 1'b1;
        default:
            return 1'b0;
    endcase
endfunction

function automatic exec_pkg::word_t result_ref(input exec_pkg::exec_func_e f,
                                               input exec_pkg::word_t a,
                                               input exec_pkg::word_t b,
                                               input exec_pkg::word_t hi,
                                               input exec_pkg::word_t lo);
    case (f)
        exec_pkg::PA:                  return a;
        exec_pkg::PB:                  return b;
        exec_pkg::ADD:                 return a + b;
        exec_pkg::SUB, exec_pkg::SUBU: return a - b;
        exec_pkg::OR:                  return a | b;
        exec_pkg::AND:                 return a & b;
        exec_pkg::XOR:                 return a ^ b;
        exec_pkg::NOR:                 return ~(a | b);
        exec_pkg::SLT:                 return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exec_pkg::SLTU:                return (a < b) ? 32'd1 : 32'd0;
        exec_pkg::SLL:                 return b << a[4:0];
        exec_pkg::SRL:                 return b >> a[4:0];
        exec_pkg::SRA:                 return exec_pkg::word_t'($signed(b) >>> a[4:0]);
        exec_pkg::MFHI:                return hi;
        exec_pkg::MFLO:                return lo;
        default:                       return 32'd0;
    endcase
endfunction

// full product as {hi, lo}
function automatic exec_pkg::dword_t mul_ref(input logic sgn,
                                             input exec_pkg::word_t a,
                                             input exec_pkg::word_t b);
    exec_pkg::dword_t x;
    exec_pkg::dword_t y;
    x = sgn ? {{32{a[31]}}, a} : {32'd0, a};
    y = sgn ? {{32{b[31]}}, b} : {32'd0, b};
    return x * y;
endfunction

// {remainder, quotient} with the remainder taking the dividend sign
function automatic exec_pkg::dword_t div_ref(input logic sgn,
                                             input exec_pkg::word_t a,
                                             input exec_pkg::word_t b);
    exec_pkg::word_t am;
    exec_pkg::word_t bm;
    exec_pkg::word_t q;
    exec_pkg::word_t r;
    am = (sgn && a[31]) ? 32'd0 - a : a;
    bm = (sgn && b[31]) ? 32'd0 - b : b;
    if (bm == 32'd0)
    begin
        q = 32'hffff_ffff;
        r = am;
    end
    else
    begin
        q = am / bm;
        r = am % bm;
    end
    if (sgn && (a[31] ^ b[31]))
        q = 32'd0 - q;
    if (sgn && a[31])
        r = 32'd0 - r;
    return {r, q};
endfunction

`endif

// File: verif/exec_stage_tb.sv
/*
 * exec_stage_tb
 * Random testbench for the execute stage, checked against a model of
 * the operand muxes, the single-cycle functions and HI/LO.
 */
`timescale 1ns/1ps

module exec_stage_tb;

    logic                   clk;
    logic                   rst;
    logic                   op_valid;
    exec_pkg::exec_op_t     op;
    exec_pkg::exec_data_t   data;
    logic                   op_ready;
    exec_pkg::exec_result_t res;
    logic                   res_valid;
    logic                   busy;
    integer                 seed = 32'h5ac1;
    exec_pkg::word_t        model_hi;
    exec_pkg::word_t        model_lo;

    `include "exec_model.svh"

    exec_stage uut
    (
        .clk            (clk),
        .rst            (rst),
        .op_valid_i     (op_valid),
        .op_i           (op),
        .data_i         (data),
        .op_ready_o     (op_ready),
        .result_o       (res),
        .result_valid_o (res_valid),
        .busy_o         (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input string what, input exec_pkg::word_t got,
                                input exec_pkg::word_t exp);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t: %s result %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_store(input exec_pkg::word_t got, input exec_pkg::word_t exp);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t: store data %h, expected %h", $time, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    function automatic exec_pkg::exec_data_t rand_data();
        exec_pkg::exec_data_t d;
        d.rs     = $random(seed);
        d.rt     = $random(seed);
        d.ext    = $random(seed);
        d.fw_alu = $random(seed);
        d.fw_mem = $random(seed);
        return d;
    endfunction

    // random sources and forwarding selects without the reserved fw code
    function automatic exec_pkg::exec_op_t rand_op(input exec_pkg::exec_func_e f);
        exec_pkg::exec_op_t o;
        o.func  = f;
        o.a_src = exec_pkg::src_sel_e'(1'($random(seed)));
        o.a_fw  = exec_pkg::fw_sel_e'(2'({$random(seed)} % 3));
        o.b_src = exec_pkg::src_sel_e'(1'($random(seed)));
        o.b_fw  = exec_pkg::fw_sel_e'(2'({$random(seed)} % 3));
        o.st_fw = exec_pkg::fw_sel_e'(2'({$random(seed)} % 3));
        return o;
    endfunction

    function automatic exec_pkg::exec_op_t plain_op(input exec_pkg::exec_func_e f);
        exec_pkg::exec_op_t o;
        o      = '0;
        o.func = f;     // A = rs, B = rt
        return o;
    endfunction

    // called on a falling edge; issues one op and checks it one cycle later
    task automatic send(input exec_pkg::exec_op_t o, input exec_pkg::exec_data_t d);
        int                   waited;
        exec_pkg::word_t      a;
        exec_pkg::word_t      b;
        exec_pkg::word_t      exp;
        logic                 has;
        exec_pkg::exec_func_e f;
        waited = 0;
        while (!op_ready)
        begin
            @(negedge clk);
            waited++;
            if (waited > 100)
                stop_run("timeout: op_ready_o stayed low for 100 cycles");
        end
        f   = o.func;
        a   = opa_ref(o, d);
        b   = opb_ref(o, d);
        has = has_result_ref(f);
        exp = result_ref(f, a, b, model_hi, model_lo);
        case (f)
            exec_pkg::MTHI:                  model_hi = a;
            exec_pkg::MTLO:                  model_lo = a;
            exec_pkg::MULT, exec_pkg::MULTU:
                {model_hi, model_lo} = mul_ref(f == exec_pkg::MULT, a, b);
            exec_pkg::DIV, exec_pkg::DIVU:
                {model_hi, model_lo} = div_ref(f == exec_pkg::DIV, a, b);
            default:                         ;
        endcase
        op_valid = 1'b1;
        op       = o;
        data     = d;
        @(negedge clk);
        op_valid = 1'b0;
        check_flag("result_valid_o", res_valid, has);
        if (has)
        begin
            check_result(f.name(), res.result, exp);
            check_store(res.store_data, fw_ref(o.st_fw, d.rt, d));
        end
    endtask

    // holds an op on the port through a mul/div and counts the stalled cycles
    task automatic hold_busy(input exec_pkg::exec_op_t o, input exec_pkg::exec_data_t d);
        int low;
        low      = 0;
        op_valid = 1'b1;
        op       = o;
        data     = d;
        while (!op_ready)
        begin
            check_flag("busy_o", busy, 1'b1);
            check_flag("result_valid_o while stalled", res_valid, 1'b0);
            low++;
            if (low > 100)
                stop_run("timeout: busy_o did not fall within 100 cycles");
            @(negedge clk);
        end
        check_flag("33-cycle stall", low == 33, 1'b1);
    endtask

    initial
    begin
        exec_pkg::exec_data_t d;
        exec_pkg::exec_data_t hd;
        exec_pkg::exec_func_e f;
        rst      = 1'b0;
        op_valid = 1'b0;
        op       = '0;
        data     = '0;
        model_hi = '0;
        model_lo = '0;
        repeat (3) @(negedge clk);
        rst = 1'b1;

        check_flag("op_ready_o after reset", op_ready, 1'b1);
        check_flag("result_valid_o after reset", res_valid, 1'b0);
        check_flag("busy_o after reset", busy, 1'b0);
        send(plain_op(exec_pkg::MFHI), rand_data());
        send(plain_op(exec_pkg::MFLO), rand_data());

        // back to back single-cycle ops from PA through SRA
        repeat (300)
            send(rand_op(exec_pkg::exec_func_e'(5'(1 + {$random(seed)} % 14))), rand_data());

        repeat (10)
        begin
            f  = $random(seed) & 1 ? exec_pkg::MULT : exec_pkg::MULTU;
            hd = rand_data();
            send(rand_op(f), rand_data());
            hold_busy(plain_op(exec_pkg::MFLO), hd);
            send(plain_op(exec_pkg::MFLO), hd);
            send(plain_op(exec_pkg::MFHI), rand_data());
        end

        for (int i = 0; i < 16; i++)
        begin
            d = rand_data();
            if (i % 4 == 0)
                d.rt = '0;      // divide by zero
            if (i % 4 == 1)
            begin
                d.rs = 32'h8000_0000;
                d.rt = 32'hffff_ffff;
            end
            f  = (i % 8 < 4) ? exec_pkg::DIV : exec_pkg::DIVU;
            hd = rand_data();
            send(plain_op(f), d);
            hold_busy(plain_op(exec_pkg::MFHI), hd);
            send(plain_op(exec_pkg::MFHI), hd);
            send(plain_op(exec_pkg::MFLO), rand_data());
        end

        repeat (10)
        begin
            send(rand_op(exec_pkg::MTHI), rand_data());
            send(rand_op(exec_pkg::MTLO), rand_data());
            send(plain_op(exec_pkg::MFHI), rand_data());
            send(plain_op(exec_pkg::MFLO), rand_data());
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
